// File: hk_pkg.sv
// Housekeeping package with bus types, register map, DNA readout timing and identity constants
`default_nettype none

package hk_pkg;

  ////////////////////////////////////////
  // Widths and types
  ////////////////////////////////////////

  localparam int unsigned bus_width = 32;
  localparam int unsigned dna_width = 57;
  localparam int unsigned git_width = 160;
  localparam int unsigned dna_count_width = 9;

  // Bus data and address
  typedef logic [bus_width-1:0] bus_word_t;
  typedef logic [bus_width-1:0] bus_addr_t;

  // Device identifier and source revision hash
  typedef logic [dna_width-1:0] dna_t;
  typedef logic [git_width-1:0] git_hash_t;

  // Startup sequencer counter
  typedef logic [dna_count_width-1:0] dna_count_t;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  // Only the low address bits take part in the decode
  localparam int unsigned hk_decode_width = 6;

  localparam logic [hk_decode_width-1:0] reg_id     = 6'h00;
  localparam logic [hk_decode_width-1:0] reg_dna_lo = 6'h04;
  localparam logic [hk_decode_width-1:0] reg_dna_hi = 6'h08;
  localparam logic [hk_decode_width-1:0] reg_status = 6'h0C;
  // Hash words, contiguous, lowest word first
  localparam logic [hk_decode_width-1:0] reg_git_0  = 6'h10;
  localparam logic [hk_decode_width-1:0] reg_git_1  = 6'h14;
  localparam logic [hk_decode_width-1:0] reg_git_2  = 6'h18;
  localparam logic [hk_decode_width-1:0] reg_git_3  = 6'h1C;
  localparam logic [hk_decode_width-1:0] reg_git_4  = 6'h20;

  ////////////////////////////////////////
  // DNA readout timing
  ////////////////////////////////////////

  // Load mode below this count
  localparam dna_count_t dna_load_end    = 9'd10;
  // Shift mode above this count
  localparam dna_count_t dna_shift_start = 9'd18;
  // Readout complete past this count
  localparam dna_count_t dna_done_count  = 9'd465;

  ////////////////////////////////////////
  // Identity constants
  ////////////////////////////////////////

  // Reserved bits, then board type 1
  localparam bus_word_t board_id = {28'h0, 4'h1};
  localparam git_hash_t git_hash = 160'h3f9c_2a71_d04e_8b56_19c7_e2a0_5d3b_96f1_0c84_7e2d;
  // Identifier held by the port model
  localparam dna_t      sim_dna  = 57'h1A5_C3D2_E1F0_4B69;

endpackage

`default_nettype wire

// File: dna_port_model.sv
// Behavioral model of the serial device identification port with load and shift
`timescale 1ns/1ps
`default_nettype none

module dna_port_model import hk_pkg::*; (
  input  wire logic bus,
  input  wire logic reset,
  // Slow port clock and controls from the reader
  input  wire logic dna_clk,
  input  wire logic dna_read,
  input  wire logic dna_shift,
  // Serial identifier bit
  output logic      dna_dout
);

  ////////////////////////////////////////
  // Slow clock edge detect
  ////////////////////////////////////////

  // Previous level of the port clock, bus domain
  logic dna_clk_q;
  logic dna_clk_rise;

  always_ff @(posedge bus) begin
    if (reset) begin
      dna_clk_q <= 1'b0;
    end else begin
      dna_clk_q <= dna_clk;
    end
  end

  // One bus cycle per slow rising edge
  assign dna_clk_rise = dna_clk & ~dna_clk_q;

  ////////////////////////////////////////
  // Identifier shift register
  ////////////////////////////////////////

  dna_t dna_sr;

  // Load has priority over shift
  always_ff @(posedge bus) begin
    if (dna_clk_rise) begin
      if (dna_read) begin
        dna_sr <= sim_dna;
      end else if (dna_shift) begin
        // MSB leaves first, zero fills behind
        dna_sr <= {dna_sr[dna_width-2:0], 1'b0};
      end
    end
  end

  // Current MSB is the serial output
  assign dna_dout = dna_sr[dna_width-1];

endmodule

`default_nettype wire

// File: dna_reader.sv
// Startup sequencer that reads the 57-bit device identifier out of the serial port
`timescale 1ns/1ps
`default_nettype none

module dna_reader import hk_pkg::*; (
  input  wire logic bus,
  input  wire logic reset,
  // Serial bit from the port
  input  wire logic dna_dout,
  // Port controls
  output logic      dna_clk,
  output logic      dna_read,
  output logic      dna_shift,
  // Captured identifier and completion flag
  output dna_t      dna_value,
  output logic      dna_done
);

  ////////////////////////////////////////
  // Startup counter
  ////////////////////////////////////////

  dna_count_t dna_cnt;

  // Runs from reset release, freezes once done
  always_ff @(posedge bus) begin
    if (reset) begin
      dna_cnt <= '0;
    end else if (!dna_done) begin
      dna_cnt <= dna_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Port controls
  ////////////////////////////////////////

  // All registered, one cycle behind the count
  always_ff @(posedge bus) begin
    if (reset) begin
      dna_clk   <= 1'b0;
      dna_read  <= 1'b0;
      dna_shift <= 1'b0;
    end else begin
      // Slow clock, period of 8 bus cycles
      dna_clk   <= dna_cnt[2];
      // Load window at the start
      dna_read  <= (dna_cnt < dna_load_end);
      // Shift from here to the end
      dna_shift <= (dna_cnt > dna_shift_start);
    end
  end

  ////////////////////////////////////////
  // Bit capture
  ////////////////////////////////////////

  logic sample_point;

  // Once per slow period, midway between port updates
  assign sample_point = (dna_cnt[2:0] == 3'd0) && !dna_done;

  // New bit enters at the LSB, MSB arrives first
  // The first two samples come before the first shift and end up shifted out
  always_ff @(posedge bus) begin
    if (reset) begin
      dna_value <= '0;
    end else if (sample_point) begin
      dna_value <= {dna_value[dna_width-2:0], dna_dout};
    end
  end

  ////////////////////////////////////////
  // Completion
  ////////////////////////////////////////

  // Sticky until the next reset
  always_ff @(posedge bus) begin
    if (reset) begin
      dna_done <= 1'b0;
    end else if (dna_cnt > dna_done_count) begin
      dna_done <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hk_regs.sv
// Bus register file returning board ID, device DNA, readout status and source hash
`timescale 1ns/1ps
`default_nettype none

module hk_regs import hk_pkg::*; (
  input  wire logic      bus,
  input  wire logic      reset,
  // Bus request
  input  wire bus_addr_t addr,
  input  wire bus_word_t wdata,
  input  wire logic      wen,
  input  wire logic      ren,
  // Identifier from the reader
  input  wire dna_t      dna_value,
  input  wire logic      dna_done,
  // Bus response
  output bus_word_t      rdata,
  output logic           ack,
  output logic           err
);

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  logic [hk_decode_width-1:0] offset;
  bus_word_t                  rdata_next;

  // High address bits are don't care
  assign offset = addr[hk_decode_width-1:0];

  always_comb begin
    case (offset)
      reg_id:     rdata_next = board_id;
      // DNA split over two words
      reg_dna_lo: rdata_next = dna_value[bus_width-1:0];
      reg_dna_hi: rdata_next = {{(2*bus_width-dna_width){1'b0}},
                                dna_value[dna_width-1:bus_width]};
      // Done flag in bit 0
      reg_status: rdata_next = {{(bus_width-1){1'b0}}, dna_done};
      // Hash words, lowest first
      reg_git_0:  rdata_next = git_hash[bus_width*0 +: bus_width];
      reg_git_1:  rdata_next = git_hash[bus_width*1 +: bus_width];
      reg_git_2:  rdata_next = git_hash[bus_width*2 +: bus_width];
      reg_git_3:  rdata_next = git_hash[bus_width*3 +: bus_width];
      reg_git_4:  rdata_next = git_hash[bus_width*4 +: bus_width];
      // Unmapped reads as zero
      default:    rdata_next = '0;
    endcase
  end

  ////////////////////////////////////////
  // Read data and acknowledge
  ////////////////////////////////////////

  logic access;

  // Any strobe, read or write
  assign access = wen | ren;

  // Read data follows the address every cycle
  always_ff @(posedge bus) begin
    if (reset) begin
      rdata <= '0;
    end else begin
      rdata <= rdata_next;
    end
  end

  // One acknowledge per strobe cycle, no wait states
  // Back-to-back strobes give back-to-back acks
  always_ff @(posedge bus) begin
    if (reset) begin
      ack <= 1'b0;
    end else begin
      ack <= access;
    end
  end

  ////////////////////////////////////////
  // Error level
  ////////////////////////////////////////

  // Bus reports error while the block is held in reset
  always_ff @(posedge bus) begin
    if (reset) begin
      err <= 1'b1;
    end else begin
      err <= 1'b0;
    end
  end

  // No writable register in the map
  // wdata is taken in and the write only earns its ack

endmodule

`default_nettype wire

// File: housekeeping.sv
// Housekeeping top level tying the DNA reader, port model and register file to the bus
`timescale 1ns/1ps
`default_nettype none

module housekeeping import hk_pkg::*; (
  input  wire logic      bus,
  input  wire logic      reset,
  // Bus request
  input  wire bus_addr_t addr,
  input  wire bus_word_t wdata,
  input  wire logic      wen,
  input  wire logic      ren,
  // Bus response
  output bus_word_t      rdata,
  output logic           ack,
  output logic           err
);

  ////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////

  // Reader to port
  logic dna_clk;
  logic dna_read;
  logic dna_shift;
  // Port to reader
  logic dna_dout;
  // Reader to registers
  dna_t dna_value;
  logic dna_done;

  ////////////////////////////////////////
  // Instances
  ////////////////////////////////////////

  // Startup readout sequencer
  dna_reader reader_i (
    .bus       (bus),
    .reset     (reset),
    .dna_dout  (dna_dout),
    .dna_clk   (dna_clk),
    .dna_read  (dna_read),
    .dna_shift (dna_shift),
    .dna_value (dna_value),
    .dna_done  (dna_done)
  );

  // Stands in for the vendor DNA primitive
  dna_port_model port_i (
    .bus       (bus),
    .reset     (reset),
    .dna_clk   (dna_clk),
    .dna_read  (dna_read),
    .dna_shift (dna_shift),
    .dna_dout  (dna_dout)
  );

  // Bus side
  hk_regs regs_i (
    .bus       (bus),
    .reset     (reset),
    .addr      (addr),
    .wdata     (wdata),
    .wen       (wen),
    .ren       (ren),
    .dna_value (dna_value),
    .dna_done  (dna_done),
    .rdata     (rdata),
    .ack       (ack),
    .err       (err)
  );

endmodule

`default_nettype wire

// File: housekeeping_sva.sv
// Bound assertions on the housekeeping bus acknowledge, error level and readout done flag
`timescale 1ns/1ps
`default_nettype none

module housekeeping_sva (
  input wire logic bus,
  input wire logic reset,
  input wire logic wen,
  input wire logic ren,
  input wire logic ack,
  input wire logic err,
  input wire logic dna_done
);

  // Running total of failed assertions
  int unsigned fail_count = 0;

  ////////////////////////////////////////
  // Bus handshake
  ////////////////////////////////////////

  // Every strobe earns an ack on the next cycle
  ack_follows_strobe: assert property (
    @(posedge bus) disable iff (reset) (wen || ren) |=> ack
  ) else begin
    $error("ack missing one cycle after a strobe");
    fail_count++;
  end

  // No ack without a strobe the cycle before
  ack_needs_strobe: assert property (
    @(posedge bus) disable iff (reset) ack |-> $past(wen || ren)
  ) else begin
    $error("ack raised without a strobe in the prior cycle");
    fail_count++;
  end

  ////////////////////////////////////////
  // Error level and done flag
  ////////////////////////////////////////

  // Error drops one clock after reset is low
  err_low_out_of_reset: assert property (
    @(posedge bus) !reset |=> !err
  ) else begin
    $error("err high although reset was low in the prior cycle");
    fail_count++;
  end

  // Sticky done
  done_holds: assert property (
    @(posedge bus) disable iff (reset) dna_done |=> dna_done
  ) else begin
    $error("dna_done fell outside reset");
    fail_count++;
  end

endmodule

bind housekeeping housekeeping_sva sva_i (
  .bus      (bus),
  .reset    (reset),
  .wen      (wen),
  .ren      (ren),
  .ack      (ack),
  .err      (err),
  .dna_done (dna_done)
);

`default_nettype wire

// File: tb_housekeeping.sv
// Table-driven testbench for the housekeeping block covering reset, DNA readout and bus access
`timescale 1ns/1ps
`default_nettype none

module tb_housekeeping import hk_pkg::*; ();

  // Watchdog budget in bus cycles
  localparam int reset_cycles   = 16;
  localparam int readout_cycles = 600;
  localparam int cycles_per_row = 4;
  localparam int margin_cycles  = 200;

  // One bus operation with its expected read data
  typedef struct packed {
    logic      is_write;
    bus_addr_t addr;
    bus_word_t expected;
  } row_t;

  logic      bus;
  logic      reset;
  bus_addr_t addr;
  bus_word_t wdata;
  logic      wen;
  logic      ren;
  bus_word_t rdata;
  logic      ack;
  logic      err;

  row_t   rows[$];
  bit     table_ready = 1'b0;
  integer seed;

  housekeeping dut_i (
    .bus   (bus),
    .reset (reset),
    .addr  (addr),
    .wdata (wdata),
    .wen   (wen),
    .ren   (ren),
    .rdata (rdata),
    .ack   (ack),
    .err   (err)
  );

  // 4 ns bus clock
  initial begin
    bus = 1'b0;
    forever #2 bus = ~bus;
  end

  ////////////////////////////////////////
  // Checks and bus tasks
  ////////////////////////////////////////

  task automatic check_value(input string name, input bus_word_t actual,
                             input bus_word_t expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h at %0t", name, actual, expected, $time);
      $display("ERRORS FOUND");
      $fatal(1, "value mismatch");
    end
  endtask

  // Single strobe, ack expected exactly one cycle later
  task automatic bus_access(input logic is_write, input bus_addr_t a, input bus_word_t d,
                            output bus_word_t data);
    @(negedge bus);
    check_value("ack", ack, 32'h0);
    addr  = a;
    wdata = d;
    wen   = is_write;
    ren   = !is_write;
    @(negedge bus);
    wen = 1'b0;
    ren = 1'b0;
    check_value("ack", ack, 32'h1);
    data = rdata;
  endtask

  function automatic void add_row(input logic is_write, input bus_addr_t a,
                                  input bus_word_t e);
    row_t r;
    r.is_write = is_write;
    r.addr     = a;
    r.expected = e;
    rows.push_back(r);
  endfunction

  // Register map values straight from the identity constants
  function automatic void add_mapped_reads();
    add_row(1'b0, 32'h00, board_id);
    add_row(1'b0, 32'h04, sim_dna[31:0]);
    add_row(1'b0, 32'h08, {7'h00, sim_dna[56:32]});
    add_row(1'b0, 32'h0C, 32'h1);
    add_row(1'b0, 32'h10, git_hash[31:0]);
    add_row(1'b0, 32'h14, git_hash[63:32]);
    add_row(1'b0, 32'h18, git_hash[95:64]);
    add_row(1'b0, 32'h1C, git_hash[127:96]);
    add_row(1'b0, 32'h20, git_hash[159:128]);
  endfunction

  function automatic void build_table();
    add_mapped_reads();
    // Unmapped and unaligned offsets
    add_row(1'b0, 32'h24, 32'h0);
    add_row(1'b0, 32'h3C, 32'h0);
    add_row(1'b0, 32'h02, 32'h0);
    // Upper address bits are ignored
    add_row(1'b0, 32'h0000_0100, board_id);
    add_row(1'b0, 32'hFFFF_FF44, sim_dna[31:0]);
    add_row(1'b0, 32'h8000_0010, git_hash[31:0]);
    add_row(1'b0, 32'h0000_0068, 32'h0);
    // Writes over every word offset
    for (int a = 0; a <= 32'h3C; a += 4) begin
      add_row(1'b1, a, 32'h0);
    end
    // Same values after the writes
    add_mapped_reads();
  endfunction

  task automatic apply_row(input row_t r);
    bus_word_t data;
    if (r.is_write) begin
      bus_access(1'b1, r.addr, $random(seed), data);
    end else begin
      bus_access(1'b0, r.addr, 32'h0, data);
      check_value($sformatf("rdata @%08h", r.addr), data, r.expected);
    end
  endtask

  // All read rows on consecutive cycles, one ack each
  task automatic burst_reads();
    bus_word_t prev_exp;
    bus_addr_t prev_addr;
    bit        pending;
    pending = 1'b0;
    @(negedge bus);
    foreach (rows[i]) begin
      if (!rows[i].is_write) begin
        if (pending) begin
          check_value("ack", ack, 32'h1);
          check_value($sformatf("rdata @%08h", prev_addr), rdata, prev_exp);
        end
        addr      = rows[i].addr;
        ren       = 1'b1;
        prev_addr = rows[i].addr;
        prev_exp  = rows[i].expected;
        pending   = 1'b1;
        @(negedge bus);
      end
    end
    ren = 1'b0;
    check_value("ack", ack, 32'h1);
    check_value($sformatf("rdata @%08h", prev_addr), rdata, prev_exp);
    @(negedge bus);
    check_value("ack", ack, 32'h0);
  endtask

  ////////////////////////////////////////
  // Watchdog and assertion monitor
  ////////////////////////////////////////

  initial begin
    wait (table_ready);
    repeat (reset_cycles + readout_cycles + cycles_per_row * rows.size() + margin_cycles)
      @(posedge bus);
    $display("Timeout: the run did not finish within its cycle budget");
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

  initial begin
    wait (dut_i.sva_i.fail_count != 0);
    $display("A bound assertion on the housekeeping block failed");
    $display("ERRORS FOUND");
    $fatal(1, "assertion failure");
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    bus_word_t data;
    int        polls;
    seed  = 71;
    reset = 1'b1;
    addr  = '0;
    wdata = '0;
    wen   = 1'b0;
    ren   = 1'b0;
    build_table();
    table_ready = 1'b1;

    // Held in reset, error up and response idle
    repeat (reset_cycles) begin
      @(negedge bus);
      check_value("err", err, 32'h1);
      check_value("ack", ack, 32'h0);
      check_value("rdata", rdata, 32'h0);
    end
    reset = 1'b0;
    @(negedge bus);
    check_value("err", err, 32'h0);
    check_value("ack", ack, 32'h0);

    // Status reads 0 until the readout is over
    polls = 0;
    do begin
      bus_access(1'b0, 32'h0C, 32'h0, data);
      if (polls == 0) begin
        check_value("rdata @0000000c", data, 32'h0);
      end else if (data !== 32'h1) begin
        check_value("rdata @0000000c", data, 32'h0);
      end
      polls++;
    end while (data !== 32'h1);

    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    burst_reads();

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
hk_pkg.sv
dna_port_model.sv
dna_reader.sv
hk_regs.sv
housekeeping.sv
housekeeping_sva.sv
tb_housekeeping.sv
